/* filelist.f */
verilog/lsu_pkg.sv
verilog/clint.sv
verilog/sram_slave.sv
verilog/axi_xbar.sv
verilog/lsu.sv
verilog/lsu_top.sv
testbench/tb_lsu_top.sv

/* run.sh */
#!/bin/sh
# build and run with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_lsu_top \
    -o sim_lsu > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_lsu > sim.log 2>&1 ; cat sim.log

grep -qx "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* testbench/tb_lsu_top.sv */
module tb_lsu_top
    import lsu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] sram_base  = 32'h8000_0000;
    localparam int          sram_words = 1024;
    localparam int          off_w      = $clog2(sram_words * 4);

    typedef enum logic {
        op_load,
        op_store
    } op_e;

    typedef enum logic [1:0] {
        chk_none,
        chk_model,  // against the byte model
        chk_zero,
        chk_rising  // above the previous load
    } check_e;

    typedef struct packed {
        op_e         op;
        mem_size_e   size;
        logic        sign;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        exp_err;
        check_e      chk;
    } entry_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        ready;
    logic        ren;
    logic        wen;
    logic        sign;
    mem_size_e   size;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        done;
    logic        err;

    entry_t      table_q [$];
    logic        table_built = 1'b0;
    logic [7:0]  ref_mem [sram_words*4];
    logic [31:0] prev_rdata = 32'h0;
    logic [31:0] lfsr_q = 32'hff9db3b5;

    lsu_top #(
        .sram_base  (sram_base),
        .sram_words (sram_words)
    ) u_dut (
        .clk    (clk),
        .arst_n (arst_n),
        .ready  (ready),
        .ren    (ren),
        .wen    (wen),
        .sign   (sign),
        .size   (size),
        .addr   (addr),
        .wdata  (wdata),
        .rdata  (rdata),
        .done   (done),
        .err    (err)
    );

    always #50 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = 32'h0;
        for (int i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1, "check on %s failed", name);
        end
    endtask

    function automatic logic [31:0] word_addr(input logic [31:0] idx);
        return sram_base + (idx << 2);
    endfunction

    // bytes at the address, little endian, then zero or sign fill
    function automatic logic [31:0] model_load(input logic [31:0] a, input mem_size_e sz,
                                               input logic sgn);
        logic [off_w-1:0] off;
        logic [7:0]       b0;
        logic [7:0]       b1;
        off = off_w'(a - sram_base);
        b0  = ref_mem[off];
        b1  = ref_mem[off + 1'b1];
        case (sz)
            size_byte: return {{24{sgn & b0[7]}}, b0};
            size_half: return {{16{sgn & b1[7]}}, b1, b0};
            default:   return {ref_mem[off + 2'd3], ref_mem[off + 2'd2], b1, b0};
        endcase
    endfunction

    task automatic model_store(input logic [31:0] a, input mem_size_e sz,
                               input logic [31:0] d);
        logic [off_w-1:0] off;
        int               n;
        off = off_w'(a - sram_base);
        n   = (sz == size_byte) ? 1 : (sz == size_half) ? 2 : 4;
        for (int i = 0; i < n; i++)
            ref_mem[off + off_w'(i)] = d[8*i +: 8];
    endtask

    task automatic add_entry(input op_e op, input mem_size_e sz, input logic sgn,
                             input logic [31:0] a, input logic [31:0] d,
                             input logic exp_err, input check_e chk);
        entry_t e;
        e = '{op: op, size: sz, sign: sgn, addr: a, wdata: d, exp_err: exp_err, chk: chk};
        table_q.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] idx [4];
        logic [31:0] d;
        logic [31:0] base;
        for (int i = 0; i < 4; i++) begin
            take_bits(4, idx[i]);
            take_bits(32, d);
            add_entry(op_store, size_word, 1'b0, word_addr(idx[i]), d, 1'b0, chk_none);
        end
        for (int i = 0; i < 4; i++)
            add_entry(op_load, size_word, 1'b0, word_addr(idx[i]), 32'h0, 1'b0, chk_model);

        // partial stores into one word
        take_bits(4, d);
        base = word_addr(32'd16 + d);
        take_bits(32, d);
        add_entry(op_store, size_word, 1'b0, base, d, 1'b0, chk_none);
        for (int off = 0; off < 4; off++) begin
            take_bits(8, d);
            add_entry(op_store, size_byte, 1'b0, base + 32'(off), d, 1'b0, chk_none);
            add_entry(op_load, size_word, 1'b0, base, 32'h0, 1'b0, chk_model);
        end
        for (int off = 0; off < 3; off++) begin
            take_bits(16, d);
            add_entry(op_store, size_half, 1'b0, base + 32'(off), d, 1'b0, chk_none);
            add_entry(op_load, size_word, 1'b0, base, 32'h0, 1'b0, chk_model);
        end

        // one word with every top bit set, one with them clear
        for (int k = 0; k < 2; k++) begin
            take_bits(32, d);
            d    = k[0] ? (d | 32'h8080_8080) : (d & 32'h7f7f_7f7f);
            base = word_addr(32'd32 + 32'(k));
            add_entry(op_store, size_word, 1'b0, base, d, 1'b0, chk_none);
            for (int off = 0; off < 4; off++) begin
                for (int s = 0; s < 2; s++)
                    add_entry(op_load, size_byte, s[0], base + 32'(off), 32'h0, 1'b0,
                              chk_model);
            end
            for (int off = 0; off < 3; off++) begin
                for (int s = 0; s < 2; s++)
                    add_entry(op_load, size_half, s[0], base + 32'(off), 32'h0, 1'b0,
                              chk_model);
            end
        end

        add_entry(op_load, size_word, 1'b0, clint_base, 32'h0, 1'b0, chk_none);
        add_entry(op_load, size_word, 1'b0, clint_base, 32'h0, 1'b0, chk_rising);
        add_entry(op_load, size_word, 1'b0, clint_base + 32'd4, 32'h0, 1'b0, chk_zero);

        // err is sticky from here on
        take_bits(32, d);
        add_entry(op_store, size_word, 1'b0, clint_base, d, 1'b1, chk_none);
        add_entry(op_load, size_word, 1'b0, 32'h1000_0000, 32'h0, 1'b1, chk_none);
    endtask

    task automatic check_done_follows_ready();
        logic last_ready;
        last_ready = 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_value("done", 32'(done), 32'(last_ready));
            ready      = i[0];
            last_ready = i[0];
        end
        @(negedge clk);
        check_value("done", 32'(done), 32'(last_ready));
        ready = 1'b0;
    endtask

    task automatic apply_entry(input entry_t e);
        @(negedge clk);
        ready = 1'b1;
        ren   = (e.op == op_load);
        wen   = (e.op == op_store);
        size  = e.size;
        sign  = e.sign;
        addr  = e.addr;
        wdata = e.wdata;
        @(negedge clk);
        ready = 1'b0; // ren/wen held so done shows the pulse
        while (!done)
            @(negedge clk);
        check_value("err", 32'(err), 32'(e.exp_err));
        case (e.chk)
            chk_model:  check_value("rdata", rdata, model_load(e.addr, e.size, e.sign));
            chk_zero:   check_value("rdata", rdata, 32'h0);
            chk_rising: check_value("mtime increase", 32'(rdata > prev_rdata), 32'd1);
            default: ;
        endcase
        if (e.op == op_load)
            prev_rdata = rdata;
        else if (!e.exp_err)
            model_store(e.addr, e.size, e.wdata);
        ren = 1'b0;
        wen = 1'b0;
    endtask

    initial begin
        wait (table_built);
        repeat (table_q.size() * 50 + 10) @(posedge clk);
        $display("timeout: done never came for a request");
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    initial begin
        arst_n = 1'b0;
        ready  = 1'b0;
        ren    = 1'b0;
        wen    = 1'b0;
        sign   = 1'b0;
        size   = size_none;
        addr   = 32'h0;
        wdata  = 32'h0;
        build_table();
        table_built = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        check_done_follows_ready();
        foreach (table_q[i])
            apply_entry(table_q[i]);

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* verilog/axi_xbar.sv */
module axi_xbar
    import lsu_pkg::*;
#(
    parameter logic [31:0] sram_base  = 32'h8000_0000,
    parameter int          sram_words = 1024
) (
    input  logic    clk,
    input  logic    arst_n,

    // master side
    input  axi_ar_t m_ar,
    output logic    m_arready,
    input  axi_aw_t m_aw,
    output logic    m_awready,
    input  axi_w_t  m_w,
    output logic    m_wready,
    output axi_r_t  m_r,
    output axi_b_t  m_b,

    // sram
    output axi_ar_t s0_ar,
    input  logic    s0_arready,
    output axi_aw_t s0_aw,
    input  logic    s0_awready,
    output axi_w_t  s0_w,
    input  logic    s0_wready,
    input  axi_r_t  s0_r,
    input  axi_b_t  s0_b,

    // clint, reads only
    output axi_ar_t s1_ar,
    input  logic    s1_arready,
    input  axi_r_t  s1_r
);

    typedef enum logic [1:0] {
        tgt_sram,
        tgt_clint,
        tgt_none
    } tgt_e;

    localparam logic [31:0] sram_bytes = 32'(sram_words) << 2;

    function automatic tgt_e decode(input logic [31:0] a);
        if (a >= sram_base && (a - sram_base) < sram_bytes)
            return tgt_sram;
        if (a >= clint_base && a <= clint_end)
            return tgt_clint;
        return tgt_none;
    endfunction

    tgt_e   rd_dec, wr_dec;
    tgt_e   rd_tgt_q, wr_tgt_q;
    logic   rd_busy, wr_busy;
    logic   err_r_valid, err_b_valid;
    logic   ar_xfer, aw_xfer, w_xfer;
    axi_r_t err_r;
    axi_b_t err_b;

    assign rd_dec = decode(m_ar.addr);
    assign wr_dec = decode(m_aw.addr);

    assign s0_ar = '{addr: m_ar.addr, size: m_ar.size,
                     valid: m_ar.valid && !rd_busy && rd_dec == tgt_sram};
    assign s1_ar = '{addr: m_ar.addr, size: m_ar.size,
                     valid: m_ar.valid && !rd_busy && rd_dec == tgt_clint};

    always_comb begin
        case (rd_dec)
            tgt_sram:  m_arready = !rd_busy && s0_arready;
            tgt_clint: m_arready = !rd_busy && s1_arready;
            default:   m_arready = !rd_busy; // error responder takes it at once
        endcase
    end

    assign err_r = '{data: 32'h0, resp: resp_decerr, last: 1'b1, valid: err_r_valid};

    always_comb begin
        case (rd_tgt_q)
            tgt_sram:  m_r = s0_r;
            tgt_clint: m_r = s1_r;
            default:   m_r = err_r;
        endcase
    end

    // writes: aw decoded, then w follows the latched target
    assign s0_aw = '{addr: m_aw.addr, size: m_aw.size,
                     valid: m_aw.valid && !wr_busy && wr_dec == tgt_sram};
    assign s0_w  = '{data: m_w.data, strb: m_w.strb, last: m_w.last,
                     valid: m_w.valid && wr_busy && wr_tgt_q == tgt_sram};

    assign m_awready = !wr_busy && (wr_dec == tgt_sram ? s0_awready : 1'b1);
    assign m_wready  = wr_busy && (wr_tgt_q == tgt_sram ? s0_wready : !err_b_valid);

    // clint is read-only
    assign err_b = '{resp: (wr_tgt_q == tgt_clint) ? resp_slverr : resp_decerr,
                     valid: err_b_valid};
    assign m_b   = (wr_tgt_q == tgt_sram) ? s0_b : err_b;

    assign ar_xfer = m_ar.valid && m_arready;
    assign aw_xfer = m_aw.valid && m_awready;
    assign w_xfer  = m_w.valid && m_wready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_busy     <= 1'b0;
            wr_busy     <= 1'b0;
            rd_tgt_q    <= tgt_none;
            wr_tgt_q    <= tgt_none;
            err_r_valid <= 1'b0;
            err_b_valid <= 1'b0;
        end else begin
            if (ar_xfer) begin
                rd_busy  <= 1'b1;
                rd_tgt_q <= rd_dec;
            end else if (m_r.valid) begin
                rd_busy <= 1'b0; // r beat done
            end

            if (aw_xfer) begin
                wr_busy  <= 1'b1;
                wr_tgt_q <= wr_dec;
            end else if (m_b.valid) begin
                wr_busy <= 1'b0;
            end

            err_r_valid <= ar_xfer && rd_dec == tgt_none;
            err_b_valid <= w_xfer && wr_tgt_q != tgt_sram;
        end
    end

    a_one_ar: assert property (@(posedge clk) disable iff (!arst_n)
        !(s0_ar.valid && s1_ar.valid));

endmodule

/* verilog/clint.sv */
module clint
    import lsu_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  axi_ar_t s_ar,
    output logic    s_arready,
    output axi_r_t  s_r
);

    logic [63:0] mtime;
    logic        r_valid_q;
    logic [31:0] r_data_q;
    logic        ar_xfer;

    assign s_arready = !r_valid_q; // idle only
    assign ar_xfer   = s_ar.valid && s_arready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtime     <= 64'h0;
            r_valid_q <= 1'b0;
        end else begin
            mtime     <= mtime + 64'd1;
            r_valid_q <= ar_xfer; // rready is always high
        end
    end

    // bit 2 picks the upper word
    always_ff @(posedge clk) begin
        if (ar_xfer)
            r_data_q <= s_ar.addr[2] ? mtime[63:32] : mtime[31:0];
    end

    assign s_r = '{data: r_data_q, resp: resp_okay, last: 1'b1, valid: r_valid_q};

endmodule

/* verilog/lsu.sv */
module lsu
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,

    // core side
    input  logic        ready,
    input  logic        ren,
    input  logic        wen,
    input  logic        sign,
    input  mem_size_e   size,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        done,
    output logic        err,

    // axi master
    output axi_ar_t     m_ar,
    input  logic        m_arready,
    output axi_aw_t     m_aw,
    input  logic        m_awready,
    output axi_w_t      m_w,
    input  logic        m_wready,
    input  axi_r_t      m_r,
    input  axi_b_t      m_b
);

    lsu_state_e  state;
    logic        done_q;
    logic        err_q;

    logic [31:0] addr_q;
    mem_size_e   size_q;
    logic        sign_q;
    logic [31:0] wdata_q;
    logic [3:0]  strb_q;
    logic [31:0] rdata_q;

    logic        r_xfer;
    logic        b_xfer;
    logic        start;

    // rready and bready are tied high, so a valid beat is a transfer
    assign r_xfer = (state == st_r) && m_r.valid;
    assign b_xfer = (state == st_b) && m_b.valid;
    assign start  = (state == st_idle) && ready && (ren || wen);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= st_idle;
            done_q <= 1'b0;
            err_q  <= 1'b0;
        end else begin
            done_q <= r_xfer || b_xfer;

            if ((r_xfer && m_r.resp != resp_okay) || (b_xfer && m_b.resp != resp_okay))
                err_q <= 1'b1; // sticky until reset

            case (state)
                st_idle: begin
                    if (ready && ren)
                        state <= st_ar;
                    else if (ready && wen)
                        state <= st_aw;
                end
                st_ar: begin
                    if (m_arready)
                        state <= st_r;
                end
                st_r: begin
                    if (done_q)
                        state <= st_idle; // leave once done has shown
                end
                st_aw: begin
                    if (m_awready)
                        state <= st_w;
                end
                st_w: begin
                    if (m_wready)
                        state <= st_b;
                end
                st_b: begin
                    if (done_q)
                        state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= addr;
            size_q  <= size;
            sign_q  <= sign;
            wdata_q <= wdata << {addr[1:0], 3'b000}; // into its byte lane
            strb_q  <= byte_strobe(size, addr[1:0]);
        end
        if (r_xfer)
            rdata_q <= extend_load(m_r.data, size_q, addr_q[1:0], sign_q);
    end

    assign m_ar = '{addr: addr_q, size: size_to_axsize(size_q), valid: (state == st_ar)};
    assign m_aw = '{addr: addr_q, size: size_to_axsize(size_q), valid: (state == st_aw)};
    assign m_w  = '{data: wdata_q, strb: strb_q, last: 1'b1, valid: (state == st_w)};

    assign rdata = rdata_q;
    assign err   = err_q;

    // no request: done just mirrors ready
    assign done = (ren || wen) ? done_q : ready;

    a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
        m_ar.valid && !m_arready |=> m_ar.valid);

    a_no_done_idle: assert property (@(posedge clk) disable iff (!arst_n)
        (state == st_idle) && (ren || wen) |-> !done);

endmodule

/* verilog/lsu_pkg.sv */
package lsu_pkg;

    typedef enum logic [1:0] {
        size_none,
        size_byte,
        size_half,
        size_word
    } mem_size_e;

    typedef enum logic [1:0] {
        resp_okay,
        resp_exokay,
        resp_slverr,
        resp_decerr
    } axi_resp_e;

    typedef enum logic [2:0] {
        st_idle,
        st_ar,
        st_r,
        st_aw,
        st_w,
        st_b
    } lsu_state_e;

    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  size;
        logic        valid;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  size;
        logic        valid;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
        logic        valid;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] data;
        axi_resp_e   resp;
        logic        last;
        logic        valid;
    } axi_r_t;

    typedef struct packed {
        axi_resp_e resp;
        logic      valid;
    } axi_b_t;

    // mtime window of the clint
    localparam logic [31:0] clint_base = 32'h0200_0048;
    localparam logic [31:0] clint_end  = 32'h0200_004f;

    function automatic logic [2:0] size_to_axsize(input mem_size_e size);
        case (size)
            size_half: return 3'd1;
            size_word: return 3'd2;
            default:   return 3'd0; // byte, and none carries no data anyway
        endcase
    endfunction

    function automatic logic [3:0] byte_strobe(input mem_size_e size, input logic [1:0] off);
        case (size)
            size_byte: return 4'b0001 << off;
            size_half: return 4'b0011 << off;
            size_word: return 4'b1111;
            default:   return 4'b0000;
        endcase
    endfunction

    function automatic logic [31:0] extend_load(input logic [31:0] data, input mem_size_e size,
                                                input logic [1:0] off, input logic sign);
        logic [31:0] shifted;
        shifted = data >> {off, 3'b000}; // lane down to bit 0
        case (size)
            size_byte: return {{24{shifted[7] & sign}}, shifted[7:0]};
            size_half: return {{16{shifted[15] & sign}}, shifted[15:0]};
            size_word: return shifted;
            default:   return 32'h0;
        endcase
    endfunction

endpackage

/* verilog/lsu_top.sv */
module lsu_top
    import lsu_pkg::*;
#(
    parameter logic [31:0] sram_base  = 32'h8000_0000,
    parameter int          sram_words = 1024
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        ready,
    input  logic        ren,
    input  logic        wen,
    input  logic        sign,
    input  mem_size_e   size,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        done,
    output logic        err
);

    axi_ar_t m_ar, s0_ar, s1_ar;
    axi_aw_t m_aw, s0_aw;
    axi_w_t  m_w, s0_w;
    axi_r_t  m_r, s0_r, s1_r;
    axi_b_t  m_b, s0_b;
    logic    m_arready, m_awready, m_wready;
    logic    s0_arready, s0_awready, s0_wready;
    logic    s1_arready;

    lsu u_lsu (
        .clk       (clk),
        .arst_n    (arst_n),
        .ready     (ready),
        .ren       (ren),
        .wen       (wen),
        .sign      (sign),
        .size      (size),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .done      (done),
        .err       (err),
        .m_ar      (m_ar),
        .m_arready (m_arready),
        .m_aw      (m_aw),
        .m_awready (m_awready),
        .m_w       (m_w),
        .m_wready  (m_wready),
        .m_r       (m_r),
        .m_b       (m_b)
    );

    axi_xbar #(
        .sram_base  (sram_base),
        .sram_words (sram_words)
    ) u_xbar (
        .clk        (clk),
        .arst_n     (arst_n),
        .m_ar       (m_ar),
        .m_arready  (m_arready),
        .m_aw       (m_aw),
        .m_awready  (m_awready),
        .m_w        (m_w),
        .m_wready   (m_wready),
        .m_r        (m_r),
        .m_b        (m_b),
        .s0_ar      (s0_ar),
        .s0_arready (s0_arready),
        .s0_aw      (s0_aw),
        .s0_awready (s0_awready),
        .s0_w       (s0_w),
        .s0_wready  (s0_wready),
        .s0_r       (s0_r),
        .s0_b       (s0_b),
        .s1_ar      (s1_ar),
        .s1_arready (s1_arready),
        .s1_r       (s1_r)
    );

    sram_slave #(
        .sram_base  (sram_base),
        .sram_words (sram_words)
    ) u_sram (
        .clk       (clk),
        .arst_n    (arst_n),
        .s_ar      (s0_ar),
        .s_aw      (s0_aw),
        .s_w       (s0_w),
        .s_arready (s0_arready),
        .s_awready (s0_awready),
        .s_wready  (s0_wready),
        .s_r       (s0_r),
        .s_b       (s0_b)
    );

    clint u_clint (
        .clk       (clk),
        .arst_n    (arst_n),
        .s_ar      (s1_ar),
        .s_arready (s1_arready),
        .s_r       (s1_r)
    );

endmodule

/* verilog/sram_slave.sv */
module sram_slave
    import lsu_pkg::*;
#(
    parameter logic [31:0] sram_base  = 32'h8000_0000,
    parameter int          sram_words = 1024
) (
    input  logic    clk,
    input  logic    arst_n,
    input  axi_ar_t s_ar,
    input  axi_aw_t s_aw,
    input  axi_w_t  s_w,
    output logic    s_arready,
    output logic    s_awready,
    output logic    s_wready,
    output axi_r_t  s_r,
    output axi_b_t  s_b
);

    localparam int idx_w = $clog2(sram_words);

    function automatic logic [idx_w-1:0] word_index(input logic [31:0] a);
        logic [31:0] off;
        off = a - sram_base;
        return off[idx_w+1:2];
    endfunction

    logic [31:0]      mem [sram_words];

    logic             r_valid_q;
    logic             b_valid_q;
    logic             aw_pending;
    logic [31:0]      r_data_q;
    logic [idx_w-1:0] waddr_q;

    logic             ar_xfer;
    logic             aw_xfer;
    logic             w_xfer;

    assign s_arready = !r_valid_q;
    assign s_awready = !aw_pending && !b_valid_q;
    assign s_wready  = aw_pending; // data only after its address

    assign ar_xfer = s_ar.valid && s_arready;
    assign aw_xfer = s_aw.valid && s_awready;
    assign w_xfer  = s_w.valid && s_wready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            r_valid_q  <= 1'b0;
            b_valid_q  <= 1'b0;
            aw_pending <= 1'b0;
        end else begin
            r_valid_q <= ar_xfer;
            b_valid_q <= w_xfer;
            if (aw_xfer)
                aw_pending <= 1'b1;
            else if (w_xfer)
                aw_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_xfer)
            r_data_q <= mem[word_index(s_ar.addr)];
        if (aw_xfer)
            waddr_q <= word_index(s_aw.addr);
        if (w_xfer) begin
            for (int i = 0; i < 4; i++) begin
                if (s_w.strb[i])
                    mem[waddr_q][8*i +: 8] <= s_w.data[8*i +: 8];
            end
        end
    end

    assign s_r = '{data: r_data_q, resp: resp_okay, last: 1'b1, valid: r_valid_q};
    assign s_b = '{resp: resp_okay, valid: b_valid_q};

    a_w_after_aw: assert property (@(posedge clk) disable iff (!arst_n)
        s_w.valid |-> aw_pending);

endmodule
